// ==== dv/fetch_front_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_macros.svh"

module fetch_front_tb
import fe_pkg::*;
();

    localparam int N_ROWS = 24;
    localparam int REDIRECT_ROW = 10;
    localparam int LINE_BYTES = `FE_LINE_BITS / 8;
    localparam int TIMEOUT_CYCLES = 200 * (2 * N_ROWS - REDIRECT_ROW);

    localparam int MEM_IDLE = 0;
    localparam int MEM_ACCEPT = 1;
    localparam int MEM_RESPOND = 2;

    // one decoded instruction as seen on the output handshake
    typedef struct packed {
        logic [`FE_XLEN-1:0]       pc;
        logic [`FE_XLEN-1:0]       inst;
        logic [`FE_ORDER_BITS-1:0] order;
        op_class_t                 cls;
        logic [4:0]                rd;
        logic [4:0]                rs1;
        logic [4:0]                rs2;
        logic                      use_rs1;
        logic                      use_rs2;
        logic [`FE_XLEN-1:0]       imm;
    } xfer_t;

    logic                      clk;
    logic                      rst;
    logic                      line_req_valid_o;
    logic [`FE_XLEN-1:0]       line_req_addr_o;
    logic                      line_req_ready_i;
    logic                      line_rsp_valid_i;
    logic [`FE_LINE_BITS-1:0]  line_rsp_data_i;
    logic                      redirect_valid_i;
    logic [`FE_XLEN-1:0]       redirect_pc_i;
    logic                      dec_valid_o;
    logic                      dec_ready_i;
    logic [`FE_XLEN-1:0]       dec_pc_o;
    logic [`FE_XLEN-1:0]       dec_inst_o;
    logic [`FE_ORDER_BITS-1:0] dec_order_o;
    op_class_t                 dec_class_o;
    logic [4:0]                dec_rd_o;
    logic [4:0]                dec_rs1_o;
    logic [4:0]                dec_rs2_o;
    logic                      dec_use_rs1_o;
    logic                      dec_use_rs2_o;
    logic [`FE_XLEN-1:0]       dec_imm_o;

    // stimulus table with expected decode
    logic [`FE_XLEN-1:0] tbl_inst [N_ROWS];
    op_class_t           tbl_class [N_ROWS];
    logic [4:0]          tbl_rd [N_ROWS];
    logic [4:0]          tbl_rs1 [N_ROWS];
    logic [4:0]          tbl_rs2 [N_ROWS];
    logic                tbl_use1 [N_ROWS];
    logic                tbl_use2 [N_ROWS];
    logic [`FE_XLEN-1:0] tbl_imm [N_ROWS];

    integer              seed = 32'h2252_a83e;
    logic                ready_en = 1'b0;
    logic                straight_run = 1'b1;
    logic                rsp_seen = 1'b0;
    int                  mem_state = MEM_IDLE;
    int                  mem_count = 0;
    logic [`FE_XLEN-1:0] mem_addr;
    logic [`FE_XLEN-1:0] next_line_addr = `FE_RESET_PC;
    xfer_t               xfer_q [$];

    fetch_front dut0 (
        .clk              (clk),
        .rst              (rst),
        .line_req_valid_o (line_req_valid_o),
        .line_req_addr_o  (line_req_addr_o),
        .line_req_ready_i (line_req_ready_i),
        .line_rsp_valid_i (line_rsp_valid_i),
        .line_rsp_data_i  (line_rsp_data_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .dec_valid_o      (dec_valid_o),
        .dec_ready_i      (dec_ready_i),
        .dec_pc_o         (dec_pc_o),
        .dec_inst_o       (dec_inst_o),
        .dec_order_o      (dec_order_o),
        .dec_class_o      (dec_class_o),
        .dec_rd_o         (dec_rd_o),
        .dec_rs1_o        (dec_rs1_o),
        .dec_rs2_o        (dec_rs2_o),
        .dec_use_rs1_o    (dec_use_rs1_o),
        .dec_use_rs2_o    (dec_use_rs2_o),
        .dec_imm_o        (dec_imm_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_class(input string name, input op_class_t exp, input op_class_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_dword(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic set_row(input int k, input logic [31:0] inst, input op_class_t cls,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic u1, input logic u2, input logic [31:0] imm);
        tbl_inst[k] = inst;
        tbl_class[k] = cls;
        tbl_rd[k] = rd;
        tbl_rs1[k] = rs1;
        tbl_rs2[k] = rs2;
        tbl_use1[k] = u1;
        tbl_use2[k] = u2;
        tbl_imm[k] = imm;
    endtask

    task automatic load_table();
        set_row(0, 32'h123452b7, alu, 5'd5, 5'd0, 5'd0, 1'b0, 1'b0, 32'h12345000);
        set_row(1, 32'hfffff517, alu, 5'd10, 5'd0, 5'd0, 1'b0, 1'b0, 32'hfffff000);
        set_row(2, 32'h010000ef, br, 5'd1, 5'd0, 5'd0, 1'b0, 1'b0, 32'h00000010);
        set_row(3, 32'hffdff06f, br, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'hfffffffc);
        set_row(4, 32'h008300e7, br, 5'd1, 5'd6, 5'd0, 1'b1, 1'b0, 32'h00000008);
        set_row(5, 32'h00208463, br, 5'd0, 5'd1, 5'd2, 1'b1, 1'b1, 32'h00000008);
        set_row(6, 32'hfe4198e3, br, 5'd0, 5'd3, 5'd4, 1'b1, 1'b1, 32'hfffffff0);
        set_row(7, 32'h00c42383, mem, 5'd7, 5'd8, 5'd0, 1'b1, 1'b0, 32'h0000000c);
        set_row(8, 32'hfff10483, mem, 5'd9, 5'd2, 5'd0, 1'b1, 1'b0, 32'hffffffff);
        set_row(9, 32'h00b62a23, mem, 5'd0, 5'd12, 5'd11, 1'b1, 1'b1, 32'h00000014);
        set_row(10, 32'hfed70c23, mem, 5'd0, 5'd14, 5'd13, 1'b1, 1'b1, 32'hfffffff8);
        set_row(11, 32'h06480793, alu, 5'd15, 5'd16, 5'd0, 1'b1, 1'b0, 32'h00000064);
        set_row(12, 32'h80008093, alu, 5'd1, 5'd1, 5'd0, 1'b1, 1'b0, 32'hfffff800);
        set_row(13, 32'h00519113, alu, 5'd2, 5'd3, 5'd0, 1'b1, 1'b0, 32'h00000005);
        set_row(14, 32'h013908b3, alu, 5'd17, 5'd18, 5'd19, 1'b1, 1'b1, 32'h00000000);
        set_row(15, 32'h416a8a33, alu, 5'd20, 5'd21, 5'd22, 1'b1, 1'b1, 32'h00000000);
        // mul and divu
        set_row(16, 32'h039c0bb3, mul, 5'd23, 5'd24, 5'd25, 1'b1, 1'b1, 32'h00000000);
        set_row(17, 32'h03cddd33, mul, 5'd26, 5'd27, 5'd28, 1'b1, 1'b1, 32'h00000000);
        // illegal opcodes and fence
        set_row(18, 32'hffffffff, none, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h00000000);
        set_row(19, 32'h00000000, none, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h00000000);
        set_row(20, 32'h0ff0000f, none, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h00000000);
        set_row(21, 32'h80000fb7, alu, 5'd31, 5'd0, 5'd0, 1'b0, 1'b0, 32'h80000000);
        set_row(22, 32'h0062c0e3, br, 5'd0, 5'd5, 5'd6, 1'b1, 1'b1, 32'h00000800);
        set_row(23, 32'h00008067, br, 5'd0, 5'd1, 5'd0, 1'b1, 1'b0, 32'h00000000);
    endtask

    // table rows from the reset pc on, nops elsewhere
    function automatic logic [`FE_XLEN-1:0] mem_word(input logic [`FE_XLEN-1:0] addr);
        logic [`FE_XLEN-1:0] ofs;
        ofs = addr - `FE_RESET_PC;
        if (ofs < 32'(4 * N_ROWS)) begin
            return tbl_inst[ofs[6:2]];
        end
        return 32'h00000013;
    endfunction

    function automatic logic [`FE_LINE_BITS-1:0] line_data(input logic [`FE_XLEN-1:0] addr);
        logic [`FE_LINE_BITS-1:0] line;
        for (int w = 0; w < `FE_LINE_BITS / `FE_XLEN; w++) begin
            line[w*`FE_XLEN +: `FE_XLEN] = mem_word(addr + 32'(4 * w));
        end
        return line;
    endfunction

    task automatic wait_transfer(output xfer_t got);
        while (xfer_q.size() == 0) begin
            @(negedge clk);
        end
        got = xfer_q.pop_front();
    endtask

    task automatic check_row(input xfer_t got, input int k, input logic [63:0] order);
        compare_word("dec_pc_o", `FE_RESET_PC + 32'(4 * k), got.pc);
        compare_word("dec_inst_o", tbl_inst[k], got.inst);
        compare_dword("dec_order_o", order, got.order);
        compare_class("dec_class_o", tbl_class[k], got.cls);
        compare_word("dec_rd_o", 32'(tbl_rd[k]), 32'(got.rd));
        compare_word("dec_rs1_o", 32'(tbl_rs1[k]), 32'(got.rs1));
        compare_word("dec_rs2_o", 32'(tbl_rs2[k]), 32'(got.rs2));
        compare_word("dec_use_rs1_o", 32'(tbl_use1[k]), 32'(got.use_rs1));
        compare_word("dec_use_rs2_o", 32'(tbl_use2[k]), 32'(got.use_rs2));
        compare_word("dec_imm_o", tbl_imm[k], got.imm);
    endtask

    // line memory, output ready and transfer capture, all on the falling edge
    initial begin : drive
        int    draw;
        xfer_t snap;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            draw = $unsigned($random(seed)) % 10;
            dec_ready_i = ready_en && (draw < 7);
            line_req_ready_i = 1'b0;
            line_rsp_valid_i = 1'b0;
            line_rsp_data_i = '0;
            if (!rsp_seen) begin
                compare_word("dec_valid_o", 32'd0, 32'(dec_valid_o));
            end
            if (mem_state == MEM_IDLE && line_req_valid_o) begin
                mem_count = $unsigned($random(seed)) % 4;
                mem_state = MEM_ACCEPT;
            end
            if (mem_state == MEM_ACCEPT) begin
                if (mem_count == 0) begin
                    line_req_ready_i = 1'b1;
                    mem_addr = line_req_addr_o;
                    if (straight_run) begin
                        compare_word("line_req_addr_o", next_line_addr, line_req_addr_o);
                        next_line_addr = next_line_addr + 32'(LINE_BYTES);
                    end
                    mem_count = 1 + $unsigned($random(seed)) % 6;
                    mem_state = MEM_RESPOND;
                end else begin
                    mem_count = mem_count - 1;
                end
            end else if (mem_state == MEM_RESPOND) begin
                mem_count = mem_count - 1;
                if (mem_count == 0) begin
                    line_rsp_valid_i = 1'b1;
                    line_rsp_data_i = line_data(mem_addr);
                    rsp_seen = 1'b1;
                    mem_state = MEM_IDLE;
                end
            end
            // outputs are stable here, so the next rising edge is a transfer
            if (dec_valid_o && dec_ready_i) begin
                snap = '{dec_pc_o, dec_inst_o, dec_order_o, dec_class_o, dec_rd_o,
                         dec_rs1_o, dec_rs2_o, dec_use_rs1_o, dec_use_rs2_o, dec_imm_o};
                xfer_q.push_back(snap);
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("The run timed out after %0d clock cycles without finishing", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin : main
        xfer_t                     got;
        logic [`FE_XLEN-1:0]       pc;
        logic [`FE_ORDER_BITS-1:0] order;
        rst = 1'b1;
        line_req_ready_i = 1'b0;
        line_rsp_valid_i = 1'b0;
        line_rsp_data_i = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        dec_ready_i = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        ready_en = 1'b1;

        for (int k = 0; k < N_ROWS; k++) begin
            wait_transfer(got);
            check_row(got, k, 64'(k));
        end

        // stop the consumer, then check the nops that slipped past the table
        @(posedge clk);
        ready_en = 1'b0;
        repeat (2) @(negedge clk);
        pc = `FE_RESET_PC + 32'(4 * N_ROWS);
        order = 64'(N_ROWS);
        while (xfer_q.size() != 0) begin
            got = xfer_q.pop_front();
            compare_word("dec_pc_o", pc, got.pc);
            compare_word("dec_inst_o", mem_word(pc), got.inst);
            compare_dword("dec_order_o", order, got.order);
            pc = pc + 32'd4;
            order = order + 64'd1;
        end

        @(posedge clk);
        straight_run = 1'b0;
        @(negedge clk);
        redirect_valid_i = 1'b1;
        redirect_pc_i = `FE_RESET_PC + 32'(4 * REDIRECT_ROW);
        @(negedge clk);
        redirect_valid_i = 1'b0;
        compare_word("dec_valid_o", 32'd0, 32'(dec_valid_o));
        @(posedge clk);
        ready_en = 1'b1;

        for (int k = REDIRECT_ROW; k < N_ROWS; k++) begin
            wait_transfer(got);
            check_row(got, k, order);
            order = order + 64'd1;
        end

        $display("Testbench passed");
        $finish;
    end

endmodule : fetch_front_tb

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_macros.svh"

module decode_stage
import fe_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      flush_i,

    input  wire logic                      in_valid_i,
    input  wire fetch_entry_t              in_entry_i,
    output logic                           in_ready_o,

    output logic                           dec_valid_o,
    input  wire logic                      dec_ready_i,
    output logic      [`FE_XLEN-1:0]       dec_pc_o,
    output logic      [`FE_XLEN-1:0]       dec_inst_o,
    output logic      [`FE_ORDER_BITS-1:0] dec_order_o,
    output op_class_t                      dec_class_o,
    output logic      [4:0]                dec_rd_o,
    output logic      [4:0]                dec_rs1_o,
    output logic      [4:0]                dec_rs2_o,
    output logic                           dec_use_rs1_o,
    output logic                           dec_use_rs2_o,
    output logic      [`FE_XLEN-1:0]       dec_imm_o
);

    logic [`FE_XLEN-1:0] inst;
    rv_opcode_t          opcode;
    logic [6:0]          funct7;

    logic [`FE_XLEN-1:0] imm_i;
    logic [`FE_XLEN-1:0] imm_s;
    logic [`FE_XLEN-1:0] imm_b;
    logic [`FE_XLEN-1:0] imm_u;
    logic [`FE_XLEN-1:0] imm_j;

    op_class_t           cls;
    logic                has_rd;
    logic                use_rs1;
    logic                use_rs2;
    logic [`FE_XLEN-1:0] imm;

    logic                accept;

    assign inst = in_entry_i.inst;
    assign opcode = rv_opcode_t'(inst[6:0]);
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        cls = none;
        has_rd = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm = '0;
        case (opcode)
            op_lui, op_auipc: begin
                cls = alu;
                has_rd = 1'b1;
                imm = imm_u;
            end
            op_jal: begin
                cls = br;
                has_rd = 1'b1;
                imm = imm_j;
            end
            op_jalr: begin
                cls = br;
                has_rd = 1'b1;
                use_rs1 = 1'b1;
                imm = imm_i;
            end
            op_branch: begin
                cls = br;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = imm_b;
            end
            op_load: begin
                cls = mem;
                has_rd = 1'b1;
                use_rs1 = 1'b1;
                imm = imm_i;
            end
            op_store: begin
                cls = mem;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = imm_s;
            end
            op_imm: begin
                cls = alu;
                has_rd = 1'b1;
                use_rs1 = 1'b1;
                imm = imm_i;
            end
            op_reg: begin
                // M extension shares the opcode
                cls = (funct7 == 7'd1) ? mul : alu;
                has_rd = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: begin
                cls = none;
            end
        endcase
    end

    // take a new entry when the register is empty or drains this cycle
    assign in_ready_o = !dec_valid_o || dec_ready_i;
    assign accept = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_pc_o <= in_entry_i.pc;
            dec_inst_o <= inst;
            dec_class_o <= cls;
            dec_rd_o <= has_rd ? inst[11:7] : 5'd0;
            dec_rs1_o <= use_rs1 ? inst[19:15] : 5'd0;
            dec_rs2_o <= use_rs2 ? inst[24:20] : 5'd0;
            dec_use_rs1_o <= use_rs1;
            dec_use_rs2_o <= use_rs2;
            dec_imm_o <= imm;
        end
    end

    // number of instructions handed downstream
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_order_o <= '0;
        end else if (dec_valid_o && dec_ready_i) begin
            dec_order_o <= dec_order_o + 1'b1;
        end
    end

    dec_hold_a: assert property (@(posedge clk) disable iff (rst)
        (dec_valid_o && !dec_ready_i && !flush_i)
            |=> (dec_valid_o && $stable(dec_pc_o) && $stable(dec_inst_o)
                 && $stable(dec_order_o) && $stable(dec_class_o)
                 && $stable(dec_rd_o) && $stable(dec_rs1_o) && $stable(dec_rs2_o)
                 && $stable(dec_use_rs1_o) && $stable(dec_use_rs2_o)
                 && $stable(dec_imm_o)));

endmodule : decode_stage

`default_nettype wire

// ==== logic/fe_macros.svh ====
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// instruction and address width
`define FE_XLEN 32

// one line is eight words
`define FE_LINE_BITS 256
`define FE_LINE_OFS 5

`define FE_QUEUE_DEPTH 16

`define FE_ORDER_BITS 64

`define FE_RESET_PC 32'haaaaa000

`endif

// ==== logic/fe_pkg.sv ====
`default_nettype none

`include "fe_macros.svh"

package fe_pkg;

    // functional unit an instruction is steered to
    typedef enum logic [2:0] {
        none,
        alu,
        mul,
        br,
        mem
    } op_class_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } rv_opcode_t;

    // one fetched instruction with its address
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] inst;
    } fetch_entry_t;

endpackage : fe_pkg

`default_nettype wire

// ==== logic/fetch_front.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_macros.svh"

module fetch_front
import fe_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,

    output logic                           line_req_valid_o,
    output logic      [`FE_XLEN-1:0]       line_req_addr_o,
    input  wire logic                      line_req_ready_i,

    input  wire logic                      line_rsp_valid_i,
    input  wire logic [`FE_LINE_BITS-1:0]  line_rsp_data_i,

    input  wire logic                      redirect_valid_i,
    input  wire logic [`FE_XLEN-1:0]       redirect_pc_i,

    output logic                           dec_valid_o,
    input  wire logic                      dec_ready_i,
    output logic      [`FE_XLEN-1:0]       dec_pc_o,
    output logic      [`FE_XLEN-1:0]       dec_inst_o,
    output logic      [`FE_ORDER_BITS-1:0] dec_order_o,
    output op_class_t                      dec_class_o,
    output logic      [4:0]                dec_rd_o,
    output logic      [4:0]                dec_rs1_o,
    output logic      [4:0]                dec_rs2_o,
    output logic                           dec_use_rs1_o,
    output logic                           dec_use_rs2_o,
    output logic      [`FE_XLEN-1:0]       dec_imm_o
);

    // fetch to queue
    logic         fq_valid;
    logic         fq_ready;
    fetch_entry_t fq_entry;

    // queue to decode
    logic         qd_valid;
    logic         qd_ready;
    fetch_entry_t qd_entry;

    line_fetch fetch0 (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .line_req_valid_o (line_req_valid_o),
        .line_req_addr_o  (line_req_addr_o),
        .line_req_ready_i (line_req_ready_i),
        .line_rsp_valid_i (line_rsp_valid_i),
        .line_rsp_data_i  (line_rsp_data_i),
        .fq_valid_o       (fq_valid),
        .fq_entry_o       (fq_entry),
        .fq_ready_i       (fq_ready)
    );

    inst_queue #(
        .DEPTH (`FE_QUEUE_DEPTH)
    ) queue0 (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_valid_i),
        .in_valid_i  (fq_valid),
        .in_entry_i  (fq_entry),
        .in_ready_o  (fq_ready),
        .out_valid_o (qd_valid),
        .out_entry_o (qd_entry),
        .out_ready_i (qd_ready)
    );

    decode_stage decode0 (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_valid_i),
        .in_valid_i    (qd_valid),
        .in_entry_i    (qd_entry),
        .in_ready_o    (qd_ready),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_pc_o      (dec_pc_o),
        .dec_inst_o    (dec_inst_o),
        .dec_order_o   (dec_order_o),
        .dec_class_o   (dec_class_o),
        .dec_rd_o      (dec_rd_o),
        .dec_rs1_o     (dec_rs1_o),
        .dec_rs2_o     (dec_rs2_o),
        .dec_use_rs1_o (dec_use_rs1_o),
        .dec_use_rs2_o (dec_use_rs2_o),
        .dec_imm_o     (dec_imm_o)
    );

endmodule : fetch_front

`default_nettype wire

// ==== logic/inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_macros.svh"

module inst_queue
import fe_pkg::*;
#(
    parameter int DEPTH = `FE_QUEUE_DEPTH
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         flush_i,

    input  wire logic         in_valid_i,
    input  wire fetch_entry_t in_entry_i,
    output logic              in_ready_o,

    output logic              out_valid_o,
    output fetch_entry_t      out_entry_o,
    input  wire logic         out_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);

    fetch_entry_t     slots [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;

    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == (PTR_W+1)'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_entry_o = slots[rd_ptr_q];

    // a full queue still takes a push when the head leaves this cycle
    assign in_ready_o = !full || out_ready_i;
    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr_q] <= in_entry_i;
        end
    end

    count_bound_a: assert property (@(posedge clk) disable iff (rst)
        count_q <= (PTR_W+1)'(DEPTH));

endmodule : inst_queue

`default_nettype wire

// ==== logic/line_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_macros.svh"

module line_fetch
import fe_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     redirect_valid_i,
    input  wire logic [`FE_XLEN-1:0]      redirect_pc_i,

    output logic                          line_req_valid_o,
    output logic      [`FE_XLEN-1:0]      line_req_addr_o,
    input  wire logic                     line_req_ready_i,

    input  wire logic                     line_rsp_valid_i,
    input  wire logic [`FE_LINE_BITS-1:0] line_rsp_data_i,

    output logic                          fq_valid_o,
    output fetch_entry_t                  fq_entry_o,
    input  wire logic                     fq_ready_i
);

    localparam int TAG_W = `FE_XLEN - `FE_LINE_OFS;

    logic [`FE_XLEN-1:0]      pc_q;

    logic [TAG_W-1:0]         buf_tag_q;
    logic [`FE_LINE_BITS-1:0] buf_data_q;
    logic                     buf_valid_q;

    logic                     req_valid_q;
    logic [TAG_W-1:0]         req_tag_q;
    logic                     pend_q;
    logic                     discard_q;

    logic                     hit;
    logic                     push;
    logic                     req_raise;
    logic                     rsp_fill;
    logic [`FE_LINE_OFS-3:0]  word_sel;

    assign hit = buf_valid_q && (pc_q[`FE_XLEN-1:`FE_LINE_OFS] == buf_tag_q);
    assign word_sel = pc_q[`FE_LINE_OFS-1:2];

    // offer straight out of the line buffer
    assign fq_valid_o = hit;
    assign fq_entry_o.pc = pc_q;
    assign fq_entry_o.inst = buf_data_q[word_sel*`FE_XLEN +: `FE_XLEN];
    assign push = fq_valid_o && fq_ready_i;

    // only one line in flight, and none raised for a pc about to be replaced
    assign req_raise = !hit && !req_valid_q && !pend_q && !redirect_valid_i;
    assign rsp_fill = pend_q && line_rsp_valid_i && !discard_q;

    assign line_req_valid_o = req_valid_q;
    assign line_req_addr_o = {req_tag_q, {`FE_LINE_OFS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FE_RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (push) begin
            pc_q <= pc_q + `FE_XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
            pend_q <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (req_valid_q && line_req_ready_i) begin
                req_valid_q <= 1'b0;
                pend_q <= 1'b1;
            end else if (req_raise) begin
                req_valid_q <= 1'b1;
            end

            if (pend_q && line_rsp_valid_i) begin
                pend_q <= 1'b0;
                discard_q <= 1'b0;
            end

            // line still comes back but belongs to the old path
            if (redirect_valid_i && (req_valid_q || (pend_q && !line_rsp_valid_i))) begin
                discard_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid_q <= 1'b0;
        end else if (rsp_fill) begin
            buf_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_raise) begin
            req_tag_q <= pc_q[`FE_XLEN-1:`FE_LINE_OFS];
        end
        if (rsp_fill) begin
            buf_tag_q <= req_tag_q;
            buf_data_q <= line_rsp_data_i;
        end
    end

    // no second request while a line is still on its way back
    req_single_a: assert property (@(posedge clk) disable iff (rst)
        line_req_valid_o |-> !pend_q);

    // request held until memory takes it
    req_stable_a: assert property (@(posedge clk) disable iff (rst)
        (line_req_valid_o && !line_req_ready_i)
            |=> (line_req_valid_o && $stable(line_req_addr_o)));

endmodule : line_fetch

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fetch_front_tb \
    -o fetch_front_sim > build.log 2>&1 \
    && ./obj_dir/fetch_front_sim > sim.log 2>&1 \
    || echo "compile or simulation step returned an error"
[ -f sim.log ] || { echo "no simulation log, see build.log"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"

// ==== src.f ====
+incdir+logic
logic/fe_pkg.sv
logic/line_fetch.sv
logic/inst_queue.sv
logic/decode_stage.sv
logic/fetch_front.sv
dv/fetch_front_tb.sv
